//--- src/rv32i_pkg.sv
////////////////////////////////////////////////////////////
// RV32I ISA definitions for the integer instruction path
////////////////////////////////////////////////////////////

`default_nettype none

package rv32i_pkg;

    // Architecture widths
    localparam int xlen = 32;
    localparam int ilen = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    // Major opcodes handled by the execute unit
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // ALU operations by funct3
    // ADD/SUB and SRL/SRA share a code, instruction bit 30 picks one
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Sticky status bits
    typedef logic [1:0] status_t;

    localparam int ST_ILLEGAL = 0;
    localparam int ST_BUS_ERR = 1;

endpackage

`default_nettype wire

//--- src/axi_fetch_pkg.sv
////////////////////////////////////////////////////////////
// Fetch bus and instruction buffer definitions
////////////////////////////////////////////////////////////

`default_nettype none

package axi_fetch_pkg;

    import rv32i_pkg::*;

    localparam int addr_w = 32;

    typedef logic [addr_w-1:0] addr_t;

    // AXI response codes, only OKAY is accepted as good
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    localparam addr_t boot_addr = 32'h0000_0000;
    localparam int    buf_depth = 4;

    // Occupancy counter, large enough for buf_depth entries
    typedef logic [2:0] cnt_t;

    // One fetched word with the address it came from
    typedef struct packed {
        addr_t           addr;
        logic [ilen-1:0] inst;
        logic            err;
    } fetch_entry_t;

endpackage

`default_nettype wire

//--- src/inst_fifo.sv
////////////////////////////////////////////////////////////
// Synchronous FIFO, payload type set by parameter
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module inst_fifo
    import axi_fetch_pkg::*;
#(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
)(
    input  logic     aclk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head_data,
    output logic     empty,
    output logic     full,
    output cnt_t     count
);

    typedef logic [$clog2(depth)-1:0] ptr_t;

    payload_t mem [depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;

    // Storage, no reset needed
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_data = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == cnt_t'(depth));

    // Producer and consumer must respect the flags
    assert property (@(posedge aclk) disable iff (rst) push |-> !full)
        else $error("push into a full FIFO");
    assert property (@(posedge aclk) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- src/inst_fetch.sv
////////////////////////////////////////////////////////////
// AXI4-Lite read master fetching instructions in order,
// outstanding requests bounded by free buffer space
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module inst_fetch
    import rv32i_pkg::*;
    import axi_fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         rst,
    input  logic         enable,
    output logic         arvalid,
    input  logic         arready,
    output addr_t        araddr,
    input  logic         rvalid,
    output logic         rready,
    input  word_t        rdata,
    input  resp_t        rresp,
    output logic         push,
    output fetch_entry_t push_data,
    input  cnt_t         buf_count
);

    addr_t pc;
    logic  ar_hs;
    logic  r_hs;
    logic  credit_ok;
    addr_t pend_addr;
    logic  pend_empty;
    logic  pend_full;
    cnt_t  pend_count;

    logic [$bits(cnt_t):0] in_use;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // Requests in flight plus words waiting in the buffer
    assign in_use    = {1'b0, pend_count} + {1'b0, buf_count};
    assign credit_ok = (in_use < ($bits(cnt_t) + 1)'(buf_depth)) && !pend_full;

    ////////////////////////////////////////////////////////////
    // Address channel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            arvalid <= 1'b0;
            pc      <= boot_addr;
            rready  <= 1'b0;
        end else begin
            // Credit always leaves room for every R beat
            rready <= 1'b1;
            if (ar_hs) begin
                arvalid <= 1'b0;
                pc      <= pc + 32'd4;
            end else if (!arvalid && enable && credit_ok) begin
                arvalid <= 1'b1;
            end
        end
    end

    assign araddr = pc;

    // Addresses still waiting for their R beat
    inst_fifo #(
        .payload_t (addr_t),
        .depth     (buf_depth)
    ) pend_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .push      (ar_hs),
        .push_data (pc),
        .pop       (r_hs),
        .head_data (pend_addr),
        .empty     (pend_empty),
        .full      (pend_full),
        .count     (pend_count)
    );

    ////////////////////////////////////////////////////////////
    // Read data channel
    ////////////////////////////////////////////////////////////

    // Responses come back in order, so the oldest address matches
    assign push           = r_hs && !pend_empty;
    assign push_data.addr = pend_addr;
    assign push_data.inst = rdata;
    assign push_data.err  = (rresp != RESP_OKAY);

    assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR channel changed while stalled");

endmodule

`default_nettype wire

//--- src/isa_registers.sv
////////////////////////////////////////////////////////////
// Integer register file, 2 read and 1 write port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module isa_registers
    import rv32i_pkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    input  reg_idx_t rs1_addr,
    output word_t    rs1_val,
    input  reg_idx_t rs2_addr,
    output word_t    rs2_val,
    input  logic     rd_wr,
    input  reg_idx_t rd_addr,
    input  word_t    rd_val
);

    word_t regs [32];

    always_ff @(posedge aclk) begin
        if (rd_wr) begin
            regs[rd_addr] <= rd_val;
        end
    end

    // x0 is hardwired to zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Execute unit filters out rd zero before the write port
    assert property (@(posedge aclk) disable iff (rst) rd_wr |-> rd_addr != '0)
        else $error("write request to x0");

endmodule

`default_nettype wire

//--- src/alu_exec.sv
////////////////////////////////////////////////////////////
// Execute unit: decode, ALU, writeback and sticky status
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module alu_exec
    import rv32i_pkg::*;
    import axi_fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         rst,
    input  logic         empty,
    input  fetch_entry_t head_data,
    output logic         pop,
    output logic         retire_valid,
    output logic         retire_rd_wr,
    output reg_idx_t     retire_rd,
    output word_t        retire_val,
    output status_t      status
);

    logic [ilen-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    word_t           rs1_val;
    word_t           rs2_val;
    word_t           imm_i;
    word_t           imm_u;
    word_t           op_b;
    word_t           alu_res;
    word_t           result;
    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            is_auipc;
    logic            legal;
    logic            exec_ok;
    logic            rd_wr;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    assign inst   = head_data.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign legal     = is_op || is_op_imm || is_lui || is_auipc;

    // Any status bit set means halted
    assign pop     = !empty && (status == '0);
    assign exec_ok = pop && !head_data.err && legal;
    assign rd_wr   = exec_ok && (rd != '0);

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign op_b = is_op ? rs2_val : imm_i;

    always_comb begin
        case (funct3)
            F3_ADD:  alu_res = (is_op && inst[30]) ? rs1_val - op_b : rs1_val + op_b;
            F3_SLL:  alu_res = rs1_val << op_b[4:0];
            F3_SLT:  alu_res = word_t'($signed(rs1_val) < $signed(op_b));
            F3_SLTU: alu_res = word_t'(rs1_val < op_b);
            F3_XOR:  alu_res = rs1_val ^ op_b;
            // Bit 30 selects arithmetic shift for SRA and SRAI
            F3_SRL:  alu_res = inst[30] ? word_t'($signed(rs1_val) >>> op_b[4:0])
                                        : rs1_val >> op_b[4:0];
            F3_OR:   alu_res = rs1_val | op_b;
            F3_AND:  alu_res = rs1_val & op_b;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        if (is_lui) begin
            result = imm_u;
        end else if (is_auipc) begin
            result = head_data.addr + imm_u;
        end else begin
            result = alu_res;
        end
    end

    // Write lands at the pop edge, ready for the next instruction
    isa_registers isa_registers_i (
        .aclk     (aclk),
        .rst      (rst),
        .rs1_addr (rs1),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd),
        .rd_val   (result)
    );

    ////////////////////////////////////////////////////////////
    // Retire port and status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_rd_wr <= 1'b0;
            status       <= '0;
        end else begin
            retire_valid <= exec_ok;
            retire_rd_wr <= rd_wr;
            if (pop && head_data.err) begin
                status[ST_BUS_ERR] <= 1'b1;
            end
            if (pop && !head_data.err && !legal) begin
                status[ST_ILLEGAL] <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (exec_ok) begin
            retire_rd  <= rd;
            retire_val <= result;
        end
    end

endmodule

`default_nettype wire

//--- src/rv32i_core.sv
////////////////////////////////////////////////////////////
// RV32I instruction path: fetch, buffer and execute
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rv32i_core
    import rv32i_pkg::*;
    import axi_fetch_pkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    input  logic     enable,
    // Instruction fetch bus, read channels only
    output logic     arvalid,
    input  logic     arready,
    output addr_t    araddr,
    input  logic     rvalid,
    output logic     rready,
    input  word_t    rdata,
    input  resp_t    rresp,
    // Writeback report
    output logic     retire_valid,
    output logic     retire_rd_wr,
    output reg_idx_t retire_rd,
    output word_t    retire_val,
    output status_t  status
);

    logic         buf_push;
    fetch_entry_t buf_push_data;
    logic         buf_pop;
    fetch_entry_t buf_head;
    logic         buf_empty;
    cnt_t         buf_count;

    inst_fetch inst_fetch_i (
        .aclk      (aclk),
        .rst       (rst),
        .enable    (enable),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .push      (buf_push),
        .push_data (buf_push_data),
        .buf_count (buf_count)
    );

    // Full flag unused, fetch credit keeps the buffer from filling over
    inst_fifo #(
        .payload_t (fetch_entry_t),
        .depth     (buf_depth)
    ) inst_buffer_i (
        .aclk      (aclk),
        .rst       (rst),
        .push      (buf_push),
        .push_data (buf_push_data),
        .pop       (buf_pop),
        .head_data (buf_head),
        .empty     (buf_empty),
        .full      (),
        .count     (buf_count)
    );

    alu_exec alu_exec_i (
        .aclk         (aclk),
        .rst          (rst),
        .empty        (buf_empty),
        .head_data    (buf_head),
        .pop          (buf_pop),
        .retire_valid (retire_valid),
        .retire_rd_wr (retire_rd_wr),
        .retire_rd    (retire_rd),
        .retire_val   (retire_val),
        .status       (status)
    );

endmodule

`default_nettype wire

//--- test/tb_rv32i_core.sv
////////////////////////////////////////////////////////////
// Testbench for the RV32I instruction path with a randomly
// stalling AXI4-Lite instruction memory
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_rv32i_core;

    localparam int wait_limit   = 2000;
    localparam int quiet_cycles = 40;
    localparam int rec_base     = 4;

    logic        aclk;
    logic        rst;
    logic        enable;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        retire_valid;
    logic        retire_rd_wr;
    logic [4:0]  retire_rd;
    logic [31:0] retire_val;
    logic [1:0]  status;

    // Header words, then three words per instruction record
    logic [31:0] pat [0:127];
    logic [31:0] pend_q [$];
    logic [31:0] ar_next;
    logic [31:0] err_addr;
    logic        inject_err;
    integer      seed;

    rv32i_core rv32i_core_i (
        .aclk         (aclk),
        .rst          (rst),
        .enable       (enable),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .retire_valid (retire_valid),
        .retire_rd_wr (retire_rd_wr),
        .retire_rd    (retire_rd),
        .retire_val   (retire_val),
        .status       (status)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d clock cycles", what, wait_limit);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic random_bit();
        random_bit = ($random(seed) & 1) == 1;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = addr >> 2;
        if (idx < pat[0]) begin
            mem_word = pat[rec_base + 3 * idx];
        end else begin
            // Words past the program are derived from the whole address
            mem_word = addr ^ 32'h5A3C_96E1;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory model making one decision per falling edge
    ////////////////////////////////////////////////////////////

    task automatic drive_bus();
        logic [31:0] addr;
        if (rst) begin
            pend_q.delete();
            ar_next = 32'h0;
            arready = 1'b0;
            rvalid  = 1'b0;
            rresp   = 2'b00;
        end else begin
            check_equal(rready, 1'b1, "rready out of reset");
            // R beat first so an address never returns in its own AR cycle
            rvalid = 1'b0;
            if (pend_q.size() > 0 && rready && random_bit()) begin
                addr   = pend_q.pop_front();
                rvalid = 1'b1;
                rdata  = mem_word(addr);
                rresp  = (inject_err && addr == err_addr) ? 2'b10 : 2'b00;
            end
            arready = random_bit();
            // Handshake lands on the next rising edge
            if (arvalid && arready) begin
                check_equal(araddr, ar_next, "fetch address");
                pend_q.push_back(araddr);
                ar_next = ar_next + 32'd4;
            end
        end
    endtask

    task automatic step();
        @(negedge aclk);
        drive_bus();
    endtask

    // Reset, run until a status bit halts the core, then check the tail
    task automatic run_program(input logic inject, input int n_expect,
                               input logic [31:0] exp_status);
        int rec;
        int retired;
        int cycles;
        inject_err = inject;
        rst        = 1'b1;
        enable     = 1'b0;
        repeat (5) step();
        // Outputs in their reset state
        check_equal(arvalid, 1'b0, "arvalid in reset");
        check_equal(rready, 1'b0, "rready in reset");
        check_equal(retire_valid, 1'b0, "retire_valid in reset");
        check_equal(status, 2'b00, "status in reset");
        check_equal(araddr, 32'h0, "araddr in reset");
        rst     = 1'b0;
        enable  = 1'b1;
        retired = 0;
        cycles  = 0;
        while (status == 2'b00 && cycles < wait_limit) begin
            step();
            cycles++;
            if (retire_valid) begin
                check_equal(retired < n_expect, 1, "retire inside expected count");
                rec = rec_base + 3 * retired;
                check_equal(retire_rd_wr, pat[rec + 1][8], "retire_rd_wr");
                if (pat[rec + 1][8]) begin
                    check_equal(retire_rd, pat[rec + 1][4:0], "retire_rd");
                    check_equal(retire_val, pat[rec + 2], "retire_val");
                end
                retired++;
            end
        end
        if (status == 2'b00) begin
            report_timeout("status bit after the program started");
        end
        // Halted core stays silent
        repeat (quiet_cycles) begin
            step();
            check_equal(retire_valid, 1'b0, "retire_valid after halt");
        end
        check_equal(retired, n_expect, "number of retires");
        check_equal(status, exp_status, "status");
    endtask

    initial begin
        seed       = 23477;
        rst        = 1'b1;
        enable     = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = 32'h0;
        rresp      = 2'b00;
        inject_err = 1'b0;
        ar_next    = 32'h0;
        $readmemh("test/core_patterns.txt", pat);
        if ($isunknown(pat[0])) begin
            $display("Pattern file test/core_patterns.txt could not be read");
            $display("Finished with errors");
            $fatal(1, "missing stimulus");
        end
        err_addr = pat[2];
        // Whole program up to the unknown opcode
        run_program(1'b0, pat[1], 32'h1);
        // Same program again with SLVERR at the listed address
        run_program(1'b1, pat[3], 32'h2);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/core_patterns.txt
// Header: instruction count, retires before the unknown opcode, SLVERR address, retires before it
// Records: instruction word, write flag and rd (1xx writes x[xx], 000 no write), expected value
@0
00000019 00000018 00000030 0000000c
@4
00c00093 101 0000000c  // addi  x1, x0, 12
ffb00113 102 fffffffb  // addi  x2, x0, -5
002081b3 103 00000007  // add   x3, x1, x2
40208233 104 00000011  // sub   x4, x1, x2
003092b3 105 00000600  // sll   x5, x1, x3
00112333 106 00000001  // slt   x6, x2, x1
001133b3 107 00000000  // sltu  x7, x2, x1
0020c433 108 fffffff7  // xor   x8, x1, x2
003154b3 109 01ffffff  // srl   x9, x2, x3
40315533 10a ffffffff  // sra   x10, x2, x3
0020e5b3 10b ffffffff  // or    x11, x1, x2
0020f633 10c 00000008  // and   x12, x1, x2
00112693 10d 00000001  // slti  x13, x2, 1
fff0b713 10e 00000001  // sltiu x14, x1, -1
0f00c793 10f 000000fc  // xori  x15, x1, 0xf0
1000e813 110 0000010c  // ori   x16, x1, 0x100
7f017893 111 000007f0  // andi  x17, x2, 0x7f0
00409913 112 000000c0  // slli  x18, x1, 4
01c15993 113 0000000f  // srli  x19, x2, 28
40115a13 114 fffffffd  // srai  x20, x2, 1
12345ab7 115 12345000  // lui   x21, 0x12345
00001b17 116 00001054  // auipc x22, 0x1 at 0x54
00108033 000 00000000  // add   x0, x1, x1
00100bb3 117 0000000c  // add   x23, x0, x1
0000000b 000 00000000  // unknown opcode

//--- sim.f
src/rv32i_pkg.sv
src/axi_fetch_pkg.sv
src/inst_fifo.sv
src/inst_fetch.sv
src/isa_registers.sv
src/alu_exec.sv
src/rv32i_core.sv
test/tb_rv32i_core.sv

//--- Makefile
# Verilator build, run, lint and clean for the RV32I instruction path

VERILATOR ?= verilator
TOP       ?= tb_rv32i_core
LINT_TOP  ?= rv32i_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter src/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)
